// File: dv/turfio_cmd_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module turfio_cmd_asserts import turfio_cmd_pkg::*; #(
    parameter int SYNC_PERIOD = 16
) (
    input wire logic                           init_clk,
    input wire logic                           rst_n_i,
    input wire logic [$clog2(SYNC_PERIOD)-1:0] sync_offset_i,
    input wire run_ctl_t                       run_ctl_o,
    input wire logic                           run_active_o,
    input wire logic [COUNT_WIDTH-1:0]         clock_count_o,
    input wire logic                           sync_o,
    input wire trig_stamp_t                    trig_stamp_o
);

    //////////////////////////////////////////////////
    // Marker spacing tracker
    //////////////////////////////////////////////////

    logic [7:0]                    gap_q;
    logic                          tracking_q;
    logic [$clog2(SYNC_PERIOD)-1:0] offset_q;

    // Realign or offset change breaks the spacing
    always_ff @(posedge init_clk) begin
        if (!rst_n_i) begin
            gap_q      <= '0;
            tracking_q <= 1'b0;
            offset_q   <= '0;
        end else begin
            offset_q <= sync_offset_i;
            gap_q    <= sync_o ? 8'd1 : gap_q + 8'd1;
            if (run_ctl_o.sync_req || sync_offset_i != offset_q) begin
                tracking_q <= 1'b0;
            end else if (sync_o) begin
                tracking_q <= 1'b1;
            end
        end
    end

    // Only checked while the offset holds steady
    sync_spacing: assert property (@(posedge init_clk) disable iff (!rst_n_i)
        (sync_o && tracking_q && sync_offset_i == offset_q) |-> gap_q == 8'(SYNC_PERIOD))
        else $error("sync marker spacing differs from the period");

    stamp_in_run: assert property (@(posedge init_clk) disable iff (!rst_n_i)
        trig_stamp_o.valid |-> $past(run_active_o, 2))
        else $error("stamp without an active run");

    reset_clears_count: assert property (@(posedge init_clk) disable iff (!rst_n_i)
        run_ctl_o.run_reset |=> clock_count_o == '0)
        else $error("count not cleared after run reset");

endmodule

bind turfio_cmd_top turfio_cmd_asserts #(.SYNC_PERIOD(SYNC_PERIOD)) u_asserts (
    .init_clk      (init_clk),
    .rst_n_i       (rst_n_i),
    .sync_offset_i (sync_offset_i),
    .run_ctl_o     (run_ctl_o),
    .run_active_o  (run_active_o),
    .clock_count_o (clock_count_o),
    .sync_o        (sync_o),
    .trig_stamp_o  (trig_stamp_o)
);

`default_nettype wire

// File: dv/turfio_cmd_tb.sv
`timescale 1ns/100ps
`default_nettype none

module turfio_cmd_tb import turfio_cmd_pkg::*;;

    localparam int SYNC_PERIOD = 16;
    localparam int HALF_PERIOD = SYNC_PERIOD / 2;
    localparam int CLK_PERIOD  = 20;
    // Long epoch test dominates the run
    localparam int TEST_CYCLES = 40150;
    localparam int TIMEOUT_NS  = TEST_CYCLES * 2 * CLK_PERIOD;

    logic                   init_clk;
    logic                   rst_n_i;
    logic [CMD_WIDTH-1:0]   cmd_i;
    logic                   cmd_valid_i;
    logic [3:0]             sync_offset_i;
    logic                   en_ext_sync_i;
    run_ctl_t               run_ctl_o;
    logic                   run_active_o;
    logic [COUNT_WIDTH-1:0] clock_count_o;
    logic                   sync_o;
    logic                   sync_pin_o;
    trig_stamp_t            trig_stamp_o;

    integer seed = 32'h3ac9f1bd;

    turfio_cmd_top #(.SYNC_PERIOD(SYNC_PERIOD)) uut (.*);

    always #(CLK_PERIOD / 2) init_clk = ~init_clk;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic stop_on_error();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopping at the first mismatch");
    endtask

    task automatic compare_ctl(input run_ctl_t got, input run_ctl_t exp, input string msg);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %b expected %b", $time, msg, got, exp);
            stop_on_error();
        end
    endtask

    task automatic compare_stamp(input trig_stamp_t got, input trig_stamp_t exp,
                                 input string msg);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
            stop_on_error();
        end
    endtask

    task automatic compare_count(input logic [COUNT_WIDTH-1:0] got,
                                 input logic [COUNT_WIDTH-1:0] exp, input string msg);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %0d expected %0d", $time, msg, got, exp);
            stop_on_error();
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %b expected %b", $time, msg, got, exp);
            stop_on_error();
        end
    endtask

    // Expected pulse vector
    function automatic run_ctl_t pulses(input logic s, input logic r, input logic st,
                                        input logic p, input logic b);
        run_ctl_t c;
        c.sync_req  = s;
        c.run_reset = r;
        c.run_stop  = st;
        c.pps       = p;
        c.bad_cmd   = b;
        return c;
    endfunction

    // Returns on edge k where the strobe is sampled
    task automatic issue(input logic [3:0] op, input logic [TRIG_TIME_WIDTH-1:0] t);
        @(posedge init_clk);
        cmd_i       <= {op, 13'd0, t};
        cmd_valid_i <= 1'b1;
        @(posedge init_clk);
        cmd_valid_i <= 1'b0;
    endtask

    // Sample just after an edge once outputs settle
    task automatic step(input int n);
        repeat (n) @(posedge init_clk);
        #1;
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic test_after_reset();
        #1;
        compare_ctl(run_ctl_o, '0, "pulses after reset");
        compare_bit(trig_stamp_o.valid, 1'b0, "stamp valid after reset");
        compare_bit(run_active_o, 1'b0, "run state after reset");
        compare_count(clock_count_o, 48'd0, "count after reset");
        step(1);
        compare_count(clock_count_o, 48'd1, "count one cycle on");
        step(1);
        compare_count(clock_count_o, 48'd2, "count two cycles on");
    endtask

    task automatic test_run_control();
        issue(OP_RESET, '0);
        step(1);
        compare_ctl(run_ctl_o, pulses(0, 1, 0, 0, 0), "run reset pulse");
        compare_bit(run_active_o, 1'b1, "run active after reset cmd");
        step(1);
        compare_count(clock_count_o, 48'd0, "count cleared by run reset");
        compare_ctl(run_ctl_o, '0, "run reset pulse ends");
        step(1);
        compare_count(clock_count_o, 48'd1, "count restarts");
        issue(OP_STOP, '0);
        step(1);
        compare_ctl(run_ctl_o, pulses(0, 0, 1, 0, 0), "run stop pulse");
        compare_bit(run_active_o, 1'b0, "run idle after stop");
    endtask

    task automatic test_sync();
        integer     val;
        logic [3:0] off;
        logic [3:0] p;
        val = $random(seed);
        off = val[3:0];
        @(posedge init_clk);
        sync_offset_i <= off;
        en_ext_sync_i <= 1'b1;
        issue(OP_SYNC, '0);
        step(1);
        compare_ctl(run_ctl_o, pulses(1, 0, 0, 0, 0), "sync request pulse");
        step(1);
        // Phase realigned to zero here
        p = 4'd0;
        repeat (2 * SYNC_PERIOD) begin
            compare_bit(sync_o, p == off, "sync marker at offset");
            compare_bit(sync_pin_o, p < HALF_PERIOD, "sync pin half period");
            step(1);
            p = p + 4'd1;
        end
        @(posedge init_clk);
        en_ext_sync_i <= 1'b0;
        #1;
        p = p + 4'd1;
        repeat (SYNC_PERIOD) begin
            compare_bit(sync_o, p == off, "sync marker with pin off");
            compare_bit(sync_pin_o, 1'b0, "sync pin disabled");
            step(1);
            p = p + 4'd1;
        end
    endtask

    // One trigger in the same or the previous epoch
    task automatic trig_once(input bit prev);
        logic [COUNT_WIDTH-1:0]     c0;
        logic [COUNT_WIDTH-1:0]     c;
        logic [TRIG_TIME_WIDTH-1:0] t;
        trig_stamp_t                exp;
        c0 = clock_count_o;
        c = c0 + 48'd3;
        t = prev ? c[14:0] + 15'd200 : c[14:0] - 15'd200;
        issue(OP_TRIG, t);
        step(1);
        compare_bit(trig_stamp_o.valid, 1'b0, "stamp not yet valid");
        compare_count(clock_count_o, c, "count seen by stamper");
        // Same epoch lands 200 counts back
        // Previous epoch lands a whole epoch minus 200 back
        exp.valid = 1'b1;
        exp.timestamp = prev ? c + 48'd200 - 48'h8000 : c - 48'd200;
        step(1);
        compare_stamp(trig_stamp_o, exp, prev ? "previous epoch stamp" : "same epoch stamp");
        step(1);
        compare_bit(trig_stamp_o.valid, 1'b0, "stamp valid is one cycle");
    endtask

    task automatic test_trigger();
        issue(OP_RESET, '0);
        step(2);
        // Run the count past the first epoch
        repeat (40000) @(posedge init_clk);
        #1;
        trig_once(1'b0);
        trig_once(1'b1);
        issue(OP_STOP, '0);
        step(2);
        issue(OP_TRIG, 15'd5);
        repeat (4) begin
            step(1);
            compare_bit(trig_stamp_o.valid, 1'b0, "trigger dropped while idle");
        end
    endtask

    task automatic test_pulses();
        issue(OP_PPS, '0);
        step(1);
        compare_ctl(run_ctl_o, pulses(0, 0, 0, 1, 0), "pps pulse");
        issue(4'hA, '0);
        step(1);
        compare_ctl(run_ctl_o, pulses(0, 0, 0, 0, 1), "illegal opcode");
        issue(OP_NOP, '0);
        step(1);
        compare_ctl(run_ctl_o, '0, "nop gives nothing");
        step(1);
        compare_ctl(run_ctl_o, '0, "nop stays quiet");
        // Three words on consecutive cycles
        @(posedge init_clk);
        cmd_i       <= {OP_PPS, 28'd0};
        cmd_valid_i <= 1'b1;
        @(posedge init_clk);
        cmd_i <= {OP_SYNC, 28'd0};
        @(posedge init_clk);
        cmd_i <= {4'hF, 28'd0};
        #1;
        compare_ctl(run_ctl_o, pulses(0, 0, 0, 1, 0), "back to back pps");
        @(posedge init_clk);
        cmd_valid_i <= 1'b0;
        #1;
        compare_ctl(run_ctl_o, pulses(1, 0, 0, 0, 0), "back to back sync");
        step(1);
        compare_ctl(run_ctl_o, pulses(0, 0, 0, 0, 1), "back to back illegal");
        step(1);
        compare_ctl(run_ctl_o, '0, "back to back done");
    endtask

    //////////////////////////////////////////////////
    // Sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        init_clk      = 1'b0;
        rst_n_i       = 1'b0;
        cmd_i         = '0;
        cmd_valid_i   = 1'b0;
        sync_offset_i = '0;
        en_ext_sync_i = 1'b0;
        repeat (4) @(posedge init_clk);
        rst_n_i <= 1'b1;
        test_after_reset();
        test_run_control();
        test_sync();
        test_trigger();
        test_pulses();
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish in the expected time");
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

// File: logic/turfio_cmd_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module turfio_cmd_decoder import turfio_cmd_pkg::*; (
    input  logic                 init_clk,
    input  logic                 rst_n_i,
    // Command word and its one-cycle strobe
    input  logic [CMD_WIDTH-1:0] cmd_i,
    input  logic                 cmd_valid_i,
    // Decoded pulses
    output run_ctl_t             run_ctl_o,
    // Trigger request toward the stamper
    output trig_req_t            trig_req_o,
    // Run state as a level
    output logic                 run_active_o
);

    //////////////////////////////////////////////////
    // Input register
    //////////////////////////////////////////////////

    // Only opcode and trigger time are kept
    // Bits 27:15 are don't-care on this side
    logic                       cmd_valid_q;
    cmd_op_e                    op_q;
    logic [TRIG_TIME_WIDTH-1:0] trig_time_q;

    // Next-state values for the output stage
    run_ctl_t   ctl_d;
    trig_req_t  trig_d;
    run_state_e state_d;
    run_state_e state_q;

    always_ff @(posedge init_clk) begin
        if (!rst_n_i) begin
            cmd_valid_q <= 1'b0;
        end else begin
            cmd_valid_q <= cmd_valid_i;
        end
    end

    // Payload, loaded with each strobe
    always_ff @(posedge init_clk) begin
        if (cmd_valid_i) begin
            op_q        <= cmd_op_e'(cmd_i[CMD_WIDTH-1 -: OP_WIDTH]);
            trig_time_q <= cmd_i[TRIG_TIME_WIDTH-1:0];
        end
    end

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    always_comb begin
        ctl_d          = '0;
        trig_d         = '0;
        state_d        = state_q;
        // Time rides along, qualified by valid
        trig_d.trig_time = trig_time_q;
        if (cmd_valid_q) begin
            case (op_q)
                // Nothing at all
                OP_NOP: begin
                end
                OP_SYNC: begin
                    ctl_d.sync_req = 1'b1;
                end
                // Start of run, counter gets cleared downstream
                OP_RESET: begin
                    ctl_d.run_reset = 1'b1;
                    state_d         = RUN_ACTIVE;
                end
                OP_STOP: begin
                    ctl_d.run_stop = 1'b1;
                    state_d        = RUN_IDLE;
                end
                OP_PPS: begin
                    ctl_d.pps = 1'b1;
                end
                // Triggers outside a run are dropped silently
                OP_TRIG: begin
                    trig_d.valid = (state_q == RUN_ACTIVE);
                end
                // Anything 6..15
                default: begin
                    ctl_d.bad_cmd = 1'b1;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    always_ff @(posedge init_clk) begin
        if (!rst_n_i) begin
            run_ctl_o  <= '0;
            trig_req_o <= '0;
            state_q    <= RUN_IDLE;
        end else begin
            run_ctl_o  <= ctl_d;
            trig_req_o <= trig_d;
            state_q    <= state_d;
        end
    end

    // Level straight off the state flop
    assign run_active_o = (state_q == RUN_ACTIVE);

endmodule

`default_nettype wire

// File: logic/turfio_cmd_pkg.sv
`default_nettype none

package turfio_cmd_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    // Full command word from the TURF link
    localparam int CMD_WIDTH = 32;
    // Opcode field at the top of the word
    localparam int OP_WIDTH = 4;
    // Trigger time carried in the low bits
    localparam int TRIG_TIME_WIDTH = 15;
    // Free-running clock count
    localparam int COUNT_WIDTH = 48;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////

    // Command opcodes, bits 31:28 of the word
    // Codes 6 through 15 are illegal
    typedef enum logic [OP_WIDTH-1:0] {
        OP_NOP   = 4'd0,
        OP_SYNC  = 4'd1,
        OP_RESET = 4'd2,
        OP_STOP  = 4'd3,
        OP_PPS   = 4'd4,
        OP_TRIG  = 4'd5
    } cmd_op_e;

    // Run state kept by the decoder
    typedef enum logic {
        RUN_IDLE   = 1'b0,
        RUN_ACTIVE = 1'b1
    } run_state_e;

    //////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////

    // Run-control pulses, one cycle each
    typedef struct packed {
        logic sync_req;
        logic run_reset;
        logic run_stop;
        logic pps;
        logic bad_cmd;
    } run_ctl_t;

    // Trigger request, 15-bit time within the epoch
    typedef struct packed {
        logic                       valid;
        logic [TRIG_TIME_WIDTH-1:0] trig_time;
    } trig_req_t;

    // Trigger with full timestamp
    typedef struct packed {
        logic                   valid;
        logic [COUNT_WIDTH-1:0] timestamp;
    } trig_stamp_t;

endpackage

`default_nettype wire

// File: logic/turfio_cmd_top.sv
`timescale 1ns/100ps
`default_nettype none

module turfio_cmd_top import turfio_cmd_pkg::*; #(
    // Sync marker period in clocks
    parameter int SYNC_PERIOD = 16
) (
    input  logic                           init_clk,
    input  logic                           rst_n_i,
    // TURF command path
    input  logic [CMD_WIDTH-1:0]           cmd_i,
    input  logic                           cmd_valid_i,
    // Sync configuration
    input  logic [$clog2(SYNC_PERIOD)-1:0] sync_offset_i,
    input  logic                           en_ext_sync_i,
    // Run control
    output run_ctl_t                       run_ctl_o,
    output logic                           run_active_o,
    // Timebase
    output logic [COUNT_WIDTH-1:0]         clock_count_o,
    output logic                           sync_o,
    output logic                           sync_pin_o,
    // Stamped triggers
    output trig_stamp_t                    trig_stamp_o
);

    //////////////////////////////////////////////////
    // Stage links
    //////////////////////////////////////////////////

    run_ctl_t               run_ctl;
    trig_req_t              trig_req;
    logic [COUNT_WIDTH-1:0] clock_count;

    assign run_ctl_o     = run_ctl;
    assign clock_count_o = clock_count;

    // Stage 1, word to pulses
    turfio_cmd_decoder u_decoder (
        .init_clk     (init_clk),
        .rst_n_i      (rst_n_i),
        .cmd_i        (cmd_i),
        .cmd_valid_i  (cmd_valid_i),
        .run_ctl_o    (run_ctl),
        .trig_req_o   (trig_req),
        .run_active_o (run_active_o)
    );

    // Stage 2, timebase
    turfio_sync_counter #(
        .SYNC_PERIOD (SYNC_PERIOD)
    ) u_sync (
        .init_clk      (init_clk),
        .rst_n_i       (rst_n_i),
        .run_ctl_i     (run_ctl),
        .sync_offset_i (sync_offset_i),
        .en_ext_sync_i (en_ext_sync_i),
        .clock_count_o (clock_count),
        .sync_o        (sync_o),
        .sync_pin_o    (sync_pin_o)
    );

    // Stage 3, full timestamp
    turfio_trig_stamp u_stamp (
        .init_clk      (init_clk),
        .rst_n_i       (rst_n_i),
        .trig_req_i    (trig_req),
        .clock_count_i (clock_count),
        .trig_stamp_o  (trig_stamp_o)
    );

endmodule

`default_nettype wire

// File: logic/turfio_sync_counter.sv
`timescale 1ns/100ps
`default_nettype none

module turfio_sync_counter import turfio_cmd_pkg::*; #(
    // Cycles between sync markers, power of two
    parameter int SYNC_PERIOD = 16
) (
    input  logic                           init_clk,
    input  logic                           rst_n_i,
    // Pulses from the decoder
    input  run_ctl_t                       run_ctl_i,
    // Phase at which the marker fires
    input  logic [$clog2(SYNC_PERIOD)-1:0] sync_offset_i,
    // Lets the sync pin toggle
    input  logic                           en_ext_sync_i,
    // Clock count, cleared by run reset
    output logic [COUNT_WIDTH-1:0]         clock_count_o,
    // Marker, one cycle per period
    output logic                           sync_o,
    // Square wave for the SYNC pin
    output logic                           sync_pin_o
);

    // Phase register width
    localparam int PHASE_WIDTH = $clog2(SYNC_PERIOD);
    // Pin is high over the first half of the period
    localparam int HALF_PERIOD = SYNC_PERIOD / 2;

    logic [COUNT_WIDTH-1:0] count_q;
    logic [PHASE_WIDTH-1:0] phase_q;

    //////////////////////////////////////////////////
    // Clock count
    //////////////////////////////////////////////////

    // Run reset zeroes it for the cycle after the pulse
    // Counting resumes from there
    always_ff @(posedge init_clk) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (run_ctl_i.run_reset) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + COUNT_WIDTH'(1);
        end
    end

    assign clock_count_o = count_q;

    //////////////////////////////////////////////////
    // Sync phase
    //////////////////////////////////////////////////

    // Wraps naturally since the period is a power of two
    // A sync request pulls it back to zero
    always_ff @(posedge init_clk) begin
        if (!rst_n_i) begin
            phase_q <= '0;
        end else if (run_ctl_i.sync_req) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + PHASE_WIDTH'(1);
        end
    end

    //////////////////////////////////////////////////
    // Marker and pin
    //////////////////////////////////////////////////

    // Offset lets the board shift the marker within the period
    assign sync_o = (phase_q == sync_offset_i);

    // Low half of the phase drives the pin high
    // held low when external sync is off
    assign sync_pin_o = en_ext_sync_i && (phase_q < PHASE_WIDTH'(HALF_PERIOD));

endmodule

`default_nettype wire

// File: logic/turfio_trig_stamp.sv
`timescale 1ns/100ps
`default_nettype none

module turfio_trig_stamp import turfio_cmd_pkg::*; (
    input  logic                   init_clk,
    input  logic                   rst_n_i,
    // Request with 15-bit time
    input  trig_req_t              trig_req_i,
    // Current clock count
    input  logic [COUNT_WIDTH-1:0] clock_count_i,
    // Trigger with full 48-bit time
    output trig_stamp_t            trig_stamp_o
);

    // One epoch spans 2^15 counts
    localparam logic [COUNT_WIDTH-1:0] EPOCH = COUNT_WIDTH'(1) << TRIG_TIME_WIDTH;

    logic [COUNT_WIDTH-1:0] candidate;
    logic                   prev_epoch;
    logic [COUNT_WIDTH-1:0] stamp_d;
    logic [COUNT_WIDTH-1:0] stamp_q;
    logic                   valid_q;

    //////////////////////////////////////////////////
    // Epoch extension
    //////////////////////////////////////////////////

    // Upper 33 bits of count with the trigger time below
    assign candidate = {clock_count_i[COUNT_WIDTH-1:TRIG_TIME_WIDTH], trig_req_i.trig_time};

    // Time ahead of the count means it was issued last epoch
    assign prev_epoch = trig_req_i.trig_time > clock_count_i[TRIG_TIME_WIDTH-1:0];

    // Step back one epoch if so
    // wraps if the count is still inside the first epoch
    assign stamp_d = prev_epoch ? (candidate - EPOCH) : candidate;

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    always_ff @(posedge init_clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= trig_req_i.valid;
        end
    end

    // Timestamp only moves on a real trigger
    always_ff @(posedge init_clk) begin
        if (trig_req_i.valid) begin
            stamp_q <= stamp_d;
        end
    end

    assign trig_stamp_o.valid     = valid_q;
    assign trig_stamp_o.timestamp = stamp_q;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the command path simulation with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -f vlog.f --top-module turfio_cmd_tb \
    -o turfio_cmd_sim > build.log 2>&1 \
    && ./obj_dir/turfio_cmd_sim > sim.log 2>&1 \
    || { cat build.log; [ -f sim.log ] && cat sim.log; echo "Simulation did not complete"; exit 1; }

cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0

// File: vlog.f
logic/turfio_cmd_pkg.sv
logic/turfio_cmd_decoder.sv
logic/turfio_sync_counter.sv
logic/turfio_trig_stamp.sv
logic/turfio_cmd_top.sv
dv/turfio_cmd_asserts.sv
dv/turfio_cmd_tb.sv
